// File: decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define DEC_INSTR_W    32
`define DEC_OP_W       6
`define DEC_FUNCT_W    6
`define DEC_REG_W      5
`define DEC_IMM_W      16
`define DEC_LINK_REG   5'd31

// LSB of each field in the instruction word
`define DEC_OP_LSB     26
`define DEC_RS_LSB     21
`define DEC_RT_LSB     16
`define DEC_RD_LSB     11
`define DEC_SH_LSB     6

`define DEC_OP_SPECIAL 6'b000000
`define DEC_OP_REGIMM  6'b000001
`define DEC_OP_J       6'b000010
`define DEC_OP_JAL     6'b000011
`define DEC_OP_BEQ     6'b000100
`define DEC_OP_BNE     6'b000101
`define DEC_OP_BLEZ    6'b000110
`define DEC_OP_BGTZ    6'b000111
`define DEC_OP_ADDI    6'b001000
`define DEC_OP_ADDIU   6'b001001
`define DEC_OP_SLTI    6'b001010
`define DEC_OP_SLTIU   6'b001011
`define DEC_OP_ANDI    6'b001100
`define DEC_OP_ORI     6'b001101
`define DEC_OP_XORI    6'b001110
`define DEC_OP_LUI     6'b001111
`define DEC_OP_LB      6'b100000
`define DEC_OP_LH      6'b100001
`define DEC_OP_LW      6'b100011
`define DEC_OP_LBU     6'b100100
`define DEC_OP_LHU     6'b100101
`define DEC_OP_SB      6'b101000
`define DEC_OP_SH      6'b101001
`define DEC_OP_SW      6'b101011

`define DEC_FN_SLL     6'b000000
`define DEC_FN_SRL     6'b000010
`define DEC_FN_SRA     6'b000011
`define DEC_FN_SLLV    6'b000100
`define DEC_FN_SRLV    6'b000110
`define DEC_FN_SRAV    6'b000111
`define DEC_FN_JR      6'b001000
`define DEC_FN_JALR    6'b001001
`define DEC_FN_MFHI    6'b010000
`define DEC_FN_MTHI    6'b010001
`define DEC_FN_MFLO    6'b010010
`define DEC_FN_MTLO    6'b010011
`define DEC_FN_MULT    6'b011000
`define DEC_FN_MULTU   6'b011001
`define DEC_FN_DIV     6'b011010
`define DEC_FN_DIVU    6'b011011
`define DEC_FN_ADD     6'b100000
`define DEC_FN_ADDU    6'b100001
`define DEC_FN_SUB     6'b100010
`define DEC_FN_SUBU    6'b100011
`define DEC_FN_AND     6'b100100
`define DEC_FN_OR      6'b100101
`define DEC_FN_XOR     6'b100110
`define DEC_FN_NOR     6'b100111
`define DEC_FN_SLT     6'b101010
`define DEC_FN_SLTU    6'b101011

// Branch function, carried in the rt field
`define DEC_RI_BLTZ    5'b00000
`define DEC_RI_BGEZ    5'b00001
`define DEC_RI_BLTZAL  5'b10000
`define DEC_RI_BGEZAL  5'b10001

`endif

// File: isa_pkg.sv
`include "decode_cfg.svh"

package isa_pkg;

    typedef logic [`DEC_INSTR_W-1:0] instr_t;
    typedef logic [`DEC_OP_W-1:0]    opcode_t;
    typedef logic [`DEC_FUNCT_W-1:0] funct_t;
    typedef logic [`DEC_REG_W-1:0]   reg_idx_t;
    typedef logic [`DEC_IMM_W-1:0]   imm_t;

    typedef struct packed {
        opcode_t               opcode;
        reg_idx_t              rs;
        reg_idx_t              rt;      // Branch function for REGIMM
        reg_idx_t              rd;
        logic [`DEC_REG_W-1:0] shamt;
        funct_t                funct;
        imm_t                  imm;     // Overlaps rd, shamt and funct
    } instr_fields_t;

    // One-hot format of the opcode
    typedef struct packed {
        logic is_special;
        logic is_regimm;
        logic is_alu_imm;
        logic is_lui;
        logic is_branch_op;
        logic is_jump_op;
        logic is_load;
        logic is_store;
        logic is_other;         // Any opcode not decoded
    } instr_class_t;

    typedef struct packed {
        instr_fields_t fields;
        instr_class_t  iclass;
    } field_beat_t;

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR
    } alu_func_t;

    typedef enum logic [2:0] {
        BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ,
        BR_BLEZ, BR_BLTZ, BR_BGEZAL, BR_BLTZAL
    } branch_t;

    typedef enum logic [1:0] {SFT_LUI, SFT_SLL, SFT_SRA, SFT_SRL} sft_func_t;
    typedef enum logic [1:0] {OUT_ALU, OUT_SHIFT, OUT_HI, OUT_LO} out_sel_t;
    typedef enum logic [1:0] {JMP_J, JMP_JR, JMP_JAL, JMP_JALR} jump_t;
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;
    typedef enum logic [1:0] {HILO_MUL, HILO_DIV, HILO_MOVE} hilo_sel_t;

    typedef struct packed {
        logic      reg_write;
        reg_idx_t  dest_reg;        // rd, rt or r31
        alu_func_t alu_func;
        logic      alu_srcb_rt;     // Else the immediate
        logic      imm_sign;
        logic      intovf_en;
        sft_func_t sft_func;
        logic      sft_srca_imm;
        logic      sft_srcb_rs;     // Else shamt
        out_sel_t  out_sel;
        logic      is_branch;
        branch_t   branch;
        logic      is_jump;
        jump_t     jump;
        logic      link;
        logic      mem_req;
        logic      mem_wr;
        mem_size_t mem_size;
        logic      rdata_sign;
        logic      mem_to_reg;
        logic      mul_en;
        logic      mul_sign;
        logic      div_en;
        logic      div_sign;
        logic      hi_wen;
        logic      lo_wen;
        hilo_sel_t hi_sel;
        hilo_sel_t lo_sel;
        logic      reserved;
    } decode_ctrl_t;

endpackage

// File: field_stage.sv
`timescale 1ns/10ps
`include "decode_cfg.svh"

module field_stage
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  instr_t      in_instr,
    output logic        mid_valid,
    input  logic        mid_ready,
    output field_beat_t mid_beat
);

    instr_fields_t fld;
    instr_class_t  cls;

    always_comb
    begin
        fld.opcode = in_instr[`DEC_OP_LSB +: `DEC_OP_W];
        fld.rs     = in_instr[`DEC_RS_LSB +: `DEC_REG_W];
        fld.rt     = in_instr[`DEC_RT_LSB +: `DEC_REG_W];
        fld.rd     = in_instr[`DEC_RD_LSB +: `DEC_REG_W];
        fld.shamt  = in_instr[`DEC_SH_LSB +: `DEC_REG_W];
        fld.funct  = in_instr[`DEC_FUNCT_W-1:0];
        fld.imm    = in_instr[`DEC_IMM_W-1:0];
    end

    always_comb
    begin
        cls = '0;
        case (fld.opcode)
            `DEC_OP_SPECIAL: cls.is_special = 1'b1;
            `DEC_OP_REGIMM:  cls.is_regimm  = 1'b1;
            `DEC_OP_LUI:     cls.is_lui     = 1'b1;
            `DEC_OP_ADDI, `DEC_OP_ADDIU, `DEC_OP_SLTI, `DEC_OP_SLTIU,
            `DEC_OP_ANDI, `DEC_OP_ORI, `DEC_OP_XORI:
                cls.is_alu_imm = 1'b1;
            `DEC_OP_BEQ, `DEC_OP_BNE, `DEC_OP_BLEZ, `DEC_OP_BGTZ:
                cls.is_branch_op = 1'b1;
            `DEC_OP_J, `DEC_OP_JAL:
                cls.is_jump_op = 1'b1;
            `DEC_OP_LB, `DEC_OP_LH, `DEC_OP_LW, `DEC_OP_LBU, `DEC_OP_LHU:
                cls.is_load = 1'b1;
            `DEC_OP_SB, `DEC_OP_SH, `DEC_OP_SW:
                cls.is_store = 1'b1;
            default:
                cls.is_other = 1'b1;    // Dropped or unknown opcode
        endcase
    end

    assign in_ready = !mid_valid || mid_ready;    // Empty or draining

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mid_valid <= 1'b0;
        else if (in_ready)
            mid_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            mid_beat <= '{fields: fld, iclass: cls};
    end

endmodule

// File: ctrl_stage.sv
`timescale 1ns/10ps
`include "decode_cfg.svh"

module ctrl_stage
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         mid_valid,
    output logic         mid_ready,
    input  field_beat_t  mid_beat,
    output logic         out_valid,
    input  logic         out_ready,
    output decode_ctrl_t out_ctrl
);

    instr_fields_t fld;
    instr_class_t  cls;
    decode_ctrl_t  ctrl_d;

    function automatic alu_func_t alu_of_funct(funct_t fn);
        case (fn)
            `DEC_FN_SUB, `DEC_FN_SUBU: return ALU_SUB;
            `DEC_FN_SLT:               return ALU_SLT;
            `DEC_FN_SLTU:              return ALU_SLTU;
            `DEC_FN_AND:               return ALU_AND;
            `DEC_FN_NOR:               return ALU_NOR;
            `DEC_FN_OR:                return ALU_OR;
            `DEC_FN_XOR:               return ALU_XOR;
            default:                   return ALU_ADD;
        endcase
    endfunction

    function automatic alu_func_t alu_of_op(opcode_t op);
        case (op)
            `DEC_OP_SLTI:  return ALU_SLT;
            `DEC_OP_SLTIU: return ALU_SLTU;
            `DEC_OP_ANDI:  return ALU_AND;
            `DEC_OP_ORI:   return ALU_OR;
            `DEC_OP_XORI:  return ALU_XOR;
            default:       return ALU_ADD;
        endcase
    endfunction

    assign fld = mid_beat.fields;
    assign cls = mid_beat.iclass;

    always_comb
    begin
        ctrl_d = '0;
        case (1'b1)
            cls.is_special:
            begin
                case (fld.funct)
                    `DEC_FN_ADD, `DEC_FN_ADDU, `DEC_FN_SUB, `DEC_FN_SUBU, `DEC_FN_SLT,
                    `DEC_FN_SLTU, `DEC_FN_AND, `DEC_FN_OR, `DEC_FN_XOR, `DEC_FN_NOR:
                    begin
                        ctrl_d.reg_write   = 1'b1;
                        ctrl_d.dest_reg    = fld.rd;
                        ctrl_d.alu_func    = alu_of_funct(fld.funct);
                        ctrl_d.alu_srcb_rt = 1'b1;
                        ctrl_d.intovf_en   = (fld.funct == `DEC_FN_ADD) ||
                                             (fld.funct == `DEC_FN_SUB);
                    end
                    `DEC_FN_SLL, `DEC_FN_SRL, `DEC_FN_SRA,
                    `DEC_FN_SLLV, `DEC_FN_SRLV, `DEC_FN_SRAV:
                    begin
                        ctrl_d.reg_write   = 1'b1;
                        ctrl_d.dest_reg    = fld.rd;
                        ctrl_d.out_sel     = OUT_SHIFT;
                        ctrl_d.sft_func    = fld.funct[0] ? SFT_SRA :
                                             (fld.funct[1] ? SFT_SRL : SFT_SLL);
                        ctrl_d.sft_srcb_rs = fld.funct[2];    // Variable forms
                    end
                    `DEC_FN_JR:
                    begin
                        ctrl_d.is_jump = 1'b1;
                        ctrl_d.jump    = JMP_JR;
                    end
                    `DEC_FN_JALR:
                    begin
                        ctrl_d.is_jump   = 1'b1;
                        ctrl_d.jump      = JMP_JALR;
                        ctrl_d.link      = 1'b1;
                        ctrl_d.reg_write = 1'b1;
                        ctrl_d.dest_reg  = fld.rd;
                    end
                    `DEC_FN_MFHI, `DEC_FN_MFLO:
                    begin
                        ctrl_d.reg_write = 1'b1;
                        ctrl_d.dest_reg  = fld.rd;
                        ctrl_d.out_sel   = fld.funct[1] ? OUT_LO : OUT_HI;
                    end
                    `DEC_FN_MTHI:
                    begin
                        ctrl_d.hi_wen = 1'b1;
                        ctrl_d.hi_sel = HILO_MOVE;
                    end
                    `DEC_FN_MTLO:
                    begin
                        ctrl_d.lo_wen = 1'b1;
                        ctrl_d.lo_sel = HILO_MOVE;
                    end
                    `DEC_FN_MULT, `DEC_FN_MULTU, `DEC_FN_DIV, `DEC_FN_DIVU:
                    begin
                        ctrl_d.alu_srcb_rt = 1'b1;
                        ctrl_d.hi_wen      = 1'b1;
                        ctrl_d.lo_wen      = 1'b1;
                        ctrl_d.mul_en      = !fld.funct[1];
                        ctrl_d.mul_sign    = (fld.funct == `DEC_FN_MULT);
                        ctrl_d.div_en      = fld.funct[1];
                        ctrl_d.div_sign    = (fld.funct == `DEC_FN_DIV);
                        ctrl_d.hi_sel      = fld.funct[1] ? HILO_DIV : HILO_MUL;
                        ctrl_d.lo_sel      = fld.funct[1] ? HILO_DIV : HILO_MUL;
                    end
                    default:
                        ctrl_d.reserved = 1'b1;
                endcase
            end
            cls.is_regimm:
            begin
                ctrl_d.is_branch = 1'b1;
                case (fld.rt)
                    `DEC_RI_BLTZ:   ctrl_d.branch = BR_BLTZ;
                    `DEC_RI_BGEZ:   ctrl_d.branch = BR_BGEZ;
                    `DEC_RI_BLTZAL: ctrl_d.branch = BR_BLTZAL;
                    `DEC_RI_BGEZAL: ctrl_d.branch = BR_BGEZAL;
                    default:
                    begin
                        ctrl_d.is_branch = 1'b0;
                        ctrl_d.reserved  = 1'b1;
                    end
                endcase
                if (ctrl_d.is_branch && fld.rt[4])    // AL forms write the return address
                begin
                    ctrl_d.link      = 1'b1;
                    ctrl_d.reg_write = 1'b1;
                    ctrl_d.dest_reg  = `DEC_LINK_REG;
                end
            end
            cls.is_alu_imm:
            begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.dest_reg  = fld.rt;
                ctrl_d.alu_func  = alu_of_op(fld.opcode);
                ctrl_d.imm_sign  = !fld.opcode[2];    // ANDI/ORI/XORI zero-extend
                ctrl_d.intovf_en = (fld.opcode == `DEC_OP_ADDI);
            end
            cls.is_lui:
            begin
                ctrl_d.reg_write    = 1'b1;
                ctrl_d.dest_reg     = fld.rt;
                ctrl_d.out_sel      = OUT_SHIFT;
                ctrl_d.sft_srca_imm = 1'b1;
            end
            cls.is_branch_op:
            begin
                ctrl_d.is_branch = 1'b1;
                case (fld.opcode)
                    `DEC_OP_BEQ:  ctrl_d.branch = BR_BEQ;
                    `DEC_OP_BNE:  ctrl_d.branch = BR_BNE;
                    `DEC_OP_BLEZ: ctrl_d.branch = BR_BLEZ;
                    default:      ctrl_d.branch = BR_BGTZ;
                endcase
            end
            cls.is_jump_op:
            begin
                ctrl_d.is_jump = 1'b1;
                if (fld.opcode == `DEC_OP_JAL)
                begin
                    ctrl_d.jump      = JMP_JAL;
                    ctrl_d.link      = 1'b1;
                    ctrl_d.reg_write = 1'b1;
                    ctrl_d.dest_reg  = `DEC_LINK_REG;
                end
            end
            cls.is_load, cls.is_store:
            begin
                ctrl_d.mem_req    = 1'b1;
                ctrl_d.imm_sign   = 1'b1;
                ctrl_d.mem_wr     = cls.is_store;
                ctrl_d.mem_size   = fld.opcode[1] ? MEM_WORD :
                                    (fld.opcode[0] ? MEM_HALF : MEM_BYTE);
                ctrl_d.rdata_sign = cls.is_load && !fld.opcode[2];    // LB, LH, LW
                ctrl_d.mem_to_reg = cls.is_load;
                ctrl_d.reg_write  = cls.is_load;
                ctrl_d.dest_reg   = cls.is_load ? fld.rt : '0;
            end
            cls.is_other:
                ctrl_d.reserved = 1'b1;
        endcase
    end

    assign mid_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (mid_ready)
            out_valid <= mid_valid;
    end

    always_ff @(posedge clk)
    begin
        if (mid_valid && mid_ready)
            out_ctrl <= ctrl_d;
    end

endmodule

// File: decode_pipe.sv
`timescale 1ns/10ps

module decode_pipe
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  instr_t       in_instr,
    output logic         out_valid,
    input  logic         out_ready,
    output decode_ctrl_t out_ctrl
);

    logic        mid_valid;
    logic        mid_ready;
    field_beat_t mid_beat;    // Fields and format class

    field_stage u_field (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready),
        .mid_beat  (mid_beat)
    );

    ctrl_stage u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready),
        .mid_beat  (mid_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_ctrl  (out_ctrl)
    );

endmodule

// File: decoder_assert.sv
`timescale 1ns/10ps

module decoder_assert
    import ctrl_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input logic         out_valid,
    input logic         out_ready,
    input decode_ctrl_t out_ctrl
);

    // Stalled word is held until taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_ctrl))
        else $error("out_ctrl or out_valid changed while out_ready was low");

    a_reset_idle: assert property (@(posedge clk)
        !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_branch_or_jump: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !(out_ctrl.is_branch && out_ctrl.is_jump))
        else $error("Control word has both is_branch and is_jump set");

    // Reserved words must not touch any state
    a_reserved_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && out_ctrl.reserved |->
            !(out_ctrl.reg_write || out_ctrl.mem_req || out_ctrl.hi_wen || out_ctrl.lo_wen))
        else $error("Reserved word has a write or request flag set");

endmodule

bind decode_pipe decoder_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_ctrl  (out_ctrl)
);

// File: decoder_tb.sv
`timescale 1ns/10ps
`include "decode_cfg.svh"

module decoder_tb
    import isa_pkg::*;
    import ctrl_pkg::*;
();

    localparam int N_INSTR = 600;
    localparam int PHASE1  = 200;            // Sent with out_ready held high
    localparam int TIMEOUT = N_INSTR * 8;

    // Kept and dropped opcodes, SPECIAL and REGIMM weighted up
    localparam opcode_t OP_TABLE [40] = '{
        `DEC_OP_SPECIAL, `DEC_OP_SPECIAL, `DEC_OP_SPECIAL, `DEC_OP_SPECIAL,
        `DEC_OP_SPECIAL, `DEC_OP_SPECIAL, `DEC_OP_SPECIAL, `DEC_OP_SPECIAL,
        `DEC_OP_REGIMM, `DEC_OP_REGIMM, `DEC_OP_REGIMM, `DEC_OP_REGIMM,
        `DEC_OP_J, `DEC_OP_JAL, `DEC_OP_BEQ, `DEC_OP_BNE, `DEC_OP_BLEZ, `DEC_OP_BGTZ,
        `DEC_OP_ADDI, `DEC_OP_ADDIU, `DEC_OP_SLTI, `DEC_OP_SLTIU,
        `DEC_OP_ANDI, `DEC_OP_ORI, `DEC_OP_XORI, `DEC_OP_LUI,
        `DEC_OP_LB, `DEC_OP_LH, `DEC_OP_LW, `DEC_OP_LBU, `DEC_OP_LHU,
        `DEC_OP_SB, `DEC_OP_SH, `DEC_OP_SW,
        6'h1c, 6'h10, 6'h22, 6'h26, 6'h2a, 6'h2e    // SPECIAL2, COP0, LWL/LWR/SWL/SWR
    };

    localparam funct_t FN_TABLE [32] = '{
        `DEC_FN_SLL, `DEC_FN_SRL, `DEC_FN_SRA, `DEC_FN_SLLV, `DEC_FN_SRLV, `DEC_FN_SRAV,
        `DEC_FN_JR, `DEC_FN_JALR, `DEC_FN_MFHI, `DEC_FN_MTHI, `DEC_FN_MFLO, `DEC_FN_MTLO,
        `DEC_FN_MULT, `DEC_FN_MULTU, `DEC_FN_DIV, `DEC_FN_DIVU,
        `DEC_FN_ADD, `DEC_FN_ADDU, `DEC_FN_SUB, `DEC_FN_SUBU,
        `DEC_FN_AND, `DEC_FN_OR, `DEC_FN_XOR, `DEC_FN_NOR, `DEC_FN_SLT, `DEC_FN_SLTU,
        6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0f, 6'h05    // MOVZ/MOVN, SYSCALL, BREAK, SYNC
    };

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    logic         in_ready;
    instr_t       in_instr;
    logic         out_valid;
    logic         out_ready;
    decode_ctrl_t out_ctrl;

    integer       seed;
    int           cycle;
    int           n_sent;
    int           n_recv;
    int           acc_cycle;
    logic [31:0]  rnd;
    instr_t       exp_instr;
    decode_ctrl_t exp_word;
    decode_ctrl_t exp_q[$];
    instr_t       instr_q[$];
    int           cycle_q[$];

    decode_pipe u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_ctrl  (out_ctrl)
    );

    always #10 clk = ~clk;

    function automatic decode_ctrl_t alu_word(reg_idx_t dest, alu_func_t fn, logic srcb_rt,
                                              logic sext, logic ovf);
        decode_ctrl_t c;
        c = '0;
        c.reg_write   = 1'b1;
        c.dest_reg    = dest;
        c.alu_func    = fn;
        c.alu_srcb_rt = srcb_rt;
        c.imm_sign    = sext;
        c.intovf_en   = ovf;
        return c;
    endfunction

    function automatic decode_ctrl_t shift_word(reg_idx_t dest, sft_func_t fn, logic var_amt);
        decode_ctrl_t c;
        c = '0;
        c.reg_write   = 1'b1;
        c.dest_reg    = dest;
        c.out_sel     = OUT_SHIFT;
        c.sft_func    = fn;
        c.sft_srcb_rs = var_amt;
        return c;
    endfunction

    function automatic decode_ctrl_t move_from(reg_idx_t dest, out_sel_t src);
        decode_ctrl_t c;
        c = '0;
        c.reg_write = 1'b1;
        c.dest_reg  = dest;
        c.out_sel   = src;
        return c;
    endfunction

    function automatic decode_ctrl_t branch_word(branch_t br);
        decode_ctrl_t c;
        c = '0;
        c.is_branch = 1'b1;
        c.branch    = br;
        return c;
    endfunction

    function automatic decode_ctrl_t jump_word(jump_t jmp);
        decode_ctrl_t c;
        c = '0;
        c.is_jump = 1'b1;
        c.jump    = jmp;
        return c;
    endfunction

    function automatic decode_ctrl_t link_to(decode_ctrl_t base, reg_idx_t dest);
        decode_ctrl_t c;
        c = base;
        c.link      = 1'b1;
        c.reg_write = 1'b1;
        c.dest_reg  = dest;
        return c;
    endfunction

    // Both HI and LO are written by multiply and divide
    function automatic decode_ctrl_t hilo_word(hilo_sel_t src, logic mul, logic sgn);
        decode_ctrl_t c;
        c = '0;
        c.alu_srcb_rt = 1'b1;
        c.hi_wen      = 1'b1;
        c.lo_wen      = 1'b1;
        c.hi_sel      = src;
        c.lo_sel      = src;
        c.mul_en      = mul;
        c.mul_sign    = mul && sgn;
        c.div_en      = !mul;
        c.div_sign    = !mul && sgn;
        return c;
    endfunction

    function automatic decode_ctrl_t mem_word(reg_idx_t rt, mem_size_t sz, logic sgn, logic load);
        decode_ctrl_t c;
        c = '0;
        c.mem_req    = 1'b1;
        c.imm_sign   = 1'b1;                 // Address offset
        c.mem_wr     = !load;
        c.mem_size   = sz;
        c.rdata_sign = sgn;
        c.mem_to_reg = load;
        c.reg_write  = load;
        c.dest_reg   = load ? rt : 5'd0;
        return c;
    endfunction

    function automatic decode_ctrl_t expected_ctrl(instr_t w);
        decode_ctrl_t c;
        reg_idx_t     rt;
        reg_idx_t     rd;
        c  = '0;
        rt = w[20:16];
        rd = w[15:11];
        case (w[31:26])
            `DEC_OP_SPECIAL:
                case (w[5:0])
                    `DEC_FN_ADD:   c = alu_word(rd, ALU_ADD, 1'b1, 1'b0, 1'b1);
                    `DEC_FN_ADDU:  c = alu_word(rd, ALU_ADD, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_SUB:   c = alu_word(rd, ALU_SUB, 1'b1, 1'b0, 1'b1);
                    `DEC_FN_SUBU:  c = alu_word(rd, ALU_SUB, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_SLT:   c = alu_word(rd, ALU_SLT, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_SLTU:  c = alu_word(rd, ALU_SLTU, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_AND:   c = alu_word(rd, ALU_AND, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_OR:    c = alu_word(rd, ALU_OR, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_XOR:   c = alu_word(rd, ALU_XOR, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_NOR:   c = alu_word(rd, ALU_NOR, 1'b1, 1'b0, 1'b0);
                    `DEC_FN_SLL:   c = shift_word(rd, SFT_SLL, 1'b0);
                    `DEC_FN_SRL:   c = shift_word(rd, SFT_SRL, 1'b0);
                    `DEC_FN_SRA:   c = shift_word(rd, SFT_SRA, 1'b0);
                    `DEC_FN_SLLV:  c = shift_word(rd, SFT_SLL, 1'b1);
                    `DEC_FN_SRLV:  c = shift_word(rd, SFT_SRL, 1'b1);
                    `DEC_FN_SRAV:  c = shift_word(rd, SFT_SRA, 1'b1);
                    `DEC_FN_JR:    c = jump_word(JMP_JR);
                    `DEC_FN_JALR:  c = link_to(jump_word(JMP_JALR), rd);
                    `DEC_FN_MFHI:  c = move_from(rd, OUT_HI);
                    `DEC_FN_MFLO:  c = move_from(rd, OUT_LO);
                    `DEC_FN_MULT:  c = hilo_word(HILO_MUL, 1'b1, 1'b1);
                    `DEC_FN_MULTU: c = hilo_word(HILO_MUL, 1'b1, 1'b0);
                    `DEC_FN_DIV:   c = hilo_word(HILO_DIV, 1'b0, 1'b1);
                    `DEC_FN_DIVU:  c = hilo_word(HILO_DIV, 1'b0, 1'b0);
                    `DEC_FN_MTHI:
                    begin
                        c.hi_wen = 1'b1;
                        c.hi_sel = HILO_MOVE;
                    end
                    `DEC_FN_MTLO:
                    begin
                        c.lo_wen = 1'b1;
                        c.lo_sel = HILO_MOVE;
                    end
                    default:       c.reserved = 1'b1;
                endcase
            `DEC_OP_REGIMM:
                case (rt)
                    `DEC_RI_BLTZ:   c = branch_word(BR_BLTZ);
                    `DEC_RI_BGEZ:   c = branch_word(BR_BGEZ);
                    `DEC_RI_BLTZAL: c = link_to(branch_word(BR_BLTZAL), `DEC_LINK_REG);
                    `DEC_RI_BGEZAL: c = link_to(branch_word(BR_BGEZAL), `DEC_LINK_REG);
                    default:        c.reserved = 1'b1;
                endcase
            `DEC_OP_J:     c = jump_word(JMP_J);
            `DEC_OP_JAL:   c = link_to(jump_word(JMP_JAL), `DEC_LINK_REG);
            `DEC_OP_BEQ:   c = branch_word(BR_BEQ);
            `DEC_OP_BNE:   c = branch_word(BR_BNE);
            `DEC_OP_BLEZ:  c = branch_word(BR_BLEZ);
            `DEC_OP_BGTZ:  c = branch_word(BR_BGTZ);
            `DEC_OP_ADDI:  c = alu_word(rt, ALU_ADD, 1'b0, 1'b1, 1'b1);
            `DEC_OP_ADDIU: c = alu_word(rt, ALU_ADD, 1'b0, 1'b1, 1'b0);
            `DEC_OP_SLTI:  c = alu_word(rt, ALU_SLT, 1'b0, 1'b1, 1'b0);
            `DEC_OP_SLTIU: c = alu_word(rt, ALU_SLTU, 1'b0, 1'b1, 1'b0);
            `DEC_OP_ANDI:  c = alu_word(rt, ALU_AND, 1'b0, 1'b0, 1'b0);
            `DEC_OP_ORI:   c = alu_word(rt, ALU_OR, 1'b0, 1'b0, 1'b0);
            `DEC_OP_XORI:  c = alu_word(rt, ALU_XOR, 1'b0, 1'b0, 1'b0);
            `DEC_OP_LUI:
            begin
                c = shift_word(rt, SFT_LUI, 1'b0);
                c.sft_srca_imm = 1'b1;
            end
            `DEC_OP_LB:    c = mem_word(rt, MEM_BYTE, 1'b1, 1'b1);
            `DEC_OP_LH:    c = mem_word(rt, MEM_HALF, 1'b1, 1'b1);
            `DEC_OP_LW:    c = mem_word(rt, MEM_WORD, 1'b1, 1'b1);
            `DEC_OP_LBU:   c = mem_word(rt, MEM_BYTE, 1'b0, 1'b1);
            `DEC_OP_LHU:   c = mem_word(rt, MEM_HALF, 1'b0, 1'b1);
            `DEC_OP_SB:    c = mem_word(rt, MEM_BYTE, 1'b0, 1'b0);
            `DEC_OP_SH:    c = mem_word(rt, MEM_HALF, 1'b0, 1'b0);
            `DEC_OP_SW:    c = mem_word(rt, MEM_WORD, 1'b0, 1'b0);
            default:       c.reserved = 1'b1;
        endcase
        return c;
    endfunction

    function automatic instr_t next_instr();
        logic [31:0] sel;
        logic [31:0] body;
        logic [5:0]  idx;
        sel  = $random(seed);
        body = $random(seed);
        if (sel[2:0] != 3'd0)                // Else a fully random word
        begin
            idx = 6'(sel[15:3] % 13'd40);
            body[31:26] = OP_TABLE[idx];
            if (body[31:26] == `DEC_OP_SPECIAL)
                body[5:0] = FN_TABLE[sel[20:16]];
            if (body[31:26] == `DEC_OP_REGIMM && sel[21])
                body[20:16] = {sel[22], 3'b000, sel[23]};    // One of the four branches
        end
        return body;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    initial
    begin
        clk       = 1'b0;
        arst_n    = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b0;
        seed      = 69;
        cycle     = 0;
        n_sent    = 0;
        n_recv    = 0;
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            cycle = cycle + 1;
            if (cycle >= TIMEOUT)
            begin
                $display("Simulation finished: FAIL");
                $fatal(1, "Timeout after %0d cycles with %0d of %0d words received",
                       cycle, n_recv, N_INSTR);
            end
            else if (n_recv == N_INSTR)
            begin
                if (!out_valid)
                begin
                    $display("Simulation finished: PASS");
                    $finish;
                end
                else
                begin
                    $display("Simulation finished: FAIL");
                    $fatal(1, "Output word appeared after the last expected one");
                end
            end
            else
            begin
                // Two words in flight fill both stages
                check_equal("in_ready", (n_sent - n_recv < 2 || out_ready) ? 64'd1 : 64'd0,
                            64'(in_ready));
                if (in_valid && in_ready)
                begin
                    exp_q.push_back(expected_ctrl(in_instr));
                    instr_q.push_back(in_instr);
                    cycle_q.push_back(cycle);
                    n_sent = n_sent + 1;
                end
                if (out_valid && out_ready)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("Simulation finished: FAIL");
                        $fatal(1, "Output word appeared with no instruction outstanding");
                    end
                    else
                    begin
                        exp_word  = exp_q.pop_front();
                        exp_instr = instr_q.pop_front();
                        acc_cycle = cycle_q.pop_front();
                        check_equal($sformatf("decode of %h", exp_instr),
                                    64'(exp_word), 64'(out_ctrl));
                        if (n_recv < PHASE1)
                            check_equal($sformatf("latency of %h", exp_instr),
                                        64'd2, 64'(cycle - acc_cycle));
                        n_recv = n_recv + 1;
                    end
                end
                rnd = $random(seed);
                if (!in_valid || in_ready)   // Hold an offer until it is taken
                begin
                    if (((n_sent < PHASE1) || (n_recv >= PHASE1 && n_sent < N_INSTR))
                        && rnd[1:0] != 2'b00)
                    begin
                        in_valid <= 1'b1;
                        in_instr <= next_instr();
                    end
                    else
                        in_valid <= 1'b0;
                end
                out_ready <= (n_recv < PHASE1) ? 1'b1 : rnd[2];
            end
        end
    end

endmodule

// File: project.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
field_stage.sv
ctrl_stage.sv
decode_pipe.sv
decoder_assert.sv
decoder_tb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module decoder_tb \
		-f project.f --Mdir obj_dir -o decoder_tb
	./obj_dir/decoder_tb

lint:
	verilator --lint-only --timing --assert --top-module decoder_tb -f project.f

clean:
	rm -rf obj_dir
